//--- verilog/xmem_cfg_pkg.sv
package xmem_cfg_pkg;

  // grid is NUM_PORTS x NUM_PORTS banks
  localparam int NUM_PORTS  = 2;
  localparam int WORD_WIDTH = 32;
  localparam int NUM_ROWS   = 64;
  // power of two
  localparam int NUM_WORDS  = 4;

  // bank read latency, then slack before write-back
  localparam int SRAM_DELAY = 2;
  localparam int UPD_DELAY  = 2;

  localparam int ROW_BITS   = $clog2(NUM_ROWS);
  localparam int WORD_BITS  = $clog2(NUM_WORDS);
  localparam int ADDR_BITS  = ROW_BITS + WORD_BITS;
  // issue to commit
  localparam int PIPE_DEPTH = SRAM_DELAY + UPD_DELAY;

endpackage

//--- verilog/xmem_op_pkg.sv
package xmem_op_pkg;

  // request kind carried down the port pipeline
  typedef enum logic [1:0] {
    OP_IDLE  = 2'd0,
    OP_READ  = 2'd1,
    OP_WRITE = 2'd2
  } xmem_op_e;

  // reset sweep sequencing
  typedef enum logic [1:0] {
    ST_SWEEP = 2'd0,
    ST_DRAIN = 2'd1,
    ST_READY = 2'd2
  } init_state_e;

endpackage

//--- verilog/xmem_init_ctrl.sv
`timescale 1ns/1ps

module xmem_init_ctrl #(
  parameter int NUM_ROWS   = xmem_cfg_pkg::NUM_ROWS,
  parameter int ROW_BITS   = xmem_cfg_pkg::ROW_BITS,
  parameter int PIPE_DEPTH = xmem_cfg_pkg::PIPE_DEPTH
) (
  input  logic                clk,
  input  logic                rst,
  output logic                ready,
  output logic                init_we,
  output logic [ROW_BITS-1:0] init_row
);
  import xmem_op_pkg::*;

  localparam int DRAIN_BITS = $clog2(PIPE_DEPTH + 1);
  localparam logic [ROW_BITS-1:0]   ROW_LAST   = ROW_BITS'(NUM_ROWS - 1);
  localparam logic [DRAIN_BITS-1:0] DRAIN_LAST = DRAIN_BITS'(PIPE_DEPTH - 1);

  init_state_e           state;
  logic [ROW_BITS-1:0]   row_cnt;
  logic [DRAIN_BITS-1:0] drain_cnt;

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= ST_SWEEP;
      row_cnt   <= '0;
      drain_cnt <= '0;
    end else begin
      case (state)
        ST_SWEEP: begin
          row_cnt <= row_cnt + 1'b1;
          if (row_cnt == ROW_LAST)
            state <= ST_DRAIN;
        end
        ST_DRAIN: begin
          drain_cnt <= drain_cnt + 1'b1;
          if (drain_cnt == DRAIN_LAST)
            state <= ST_READY;
        end
        default: state <= ST_READY;
      endcase
    end
  end

  assign init_we  = (state == ST_SWEEP);
  assign init_row = row_cnt;
  assign ready    = (state == ST_READY);

  // ready follows the last zero write after the pipelines drain
  assert property (@(posedge clk) disable iff (rst)
    $rose(ready) |-> $past(init_we, PIPE_DEPTH + 1));

endmodule

//--- verilog/xmem_port_pipe.sv
`timescale 1ns/1ps

module xmem_port_pipe #(
  parameter int ADDR_BITS  = xmem_cfg_pkg::ADDR_BITS,
  parameter int ROW_BITS   = xmem_cfg_pkg::ROW_BITS,
  parameter int WORD_BITS  = xmem_cfg_pkg::WORD_BITS,
  parameter int WORD_WIDTH = xmem_cfg_pkg::WORD_WIDTH,
  parameter int SRAM_DELAY = xmem_cfg_pkg::SRAM_DELAY,
  parameter int PIPE_DEPTH = xmem_cfg_pkg::PIPE_DEPTH
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   ready,
  input  logic                   vread,
  input  logic                   vwrite,
  input  logic [ADDR_BITS-1:0]   vaddr,
  input  logic [WORD_WIDTH-1:0]  vdin,
  output logic                   iss_rd,
  output logic [ROW_BITS-1:0]    iss_row,
  output logic                   rs_vld,
  output logic [WORD_BITS-1:0]   rs_word,
  output xmem_op_pkg::xmem_op_e  cm_op,
  output logic [ROW_BITS-1:0]    cm_row,
  output logic [WORD_BITS-1:0]   cm_word,
  output logic [WORD_WIDTH-1:0]  cm_data
);
  import xmem_op_pkg::*;

  xmem_op_e              iss_op;
  xmem_op_e              op_q   [PIPE_DEPTH];
  logic [ROW_BITS-1:0]   row_q  [PIPE_DEPTH];
  logic [WORD_BITS-1:0]  word_q [PIPE_DEPTH];
  logic [WORD_WIDTH-1:0] data_q [PIPE_DEPTH];

  // nothing is taken before the sweep is done
  always_comb begin
    iss_op = OP_IDLE;
    if (ready && vwrite)
      iss_op = OP_WRITE;
    else if (ready && vread)
      iss_op = OP_READ;
  end

  // writes read the row too, for the update
  assign iss_rd  = (iss_op != OP_IDLE);
  assign iss_row = vaddr[ADDR_BITS-1:WORD_BITS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int k = 0; k < PIPE_DEPTH; k++)
        op_q[k] <= OP_IDLE;
    end else begin
      op_q[0] <= iss_op;
      for (int k = 1; k < PIPE_DEPTH; k++)
        op_q[k] <= op_q[k-1];
    end
  end

  always_ff @(posedge clk) begin
    row_q[0]  <= iss_row;
    word_q[0] <= vaddr[WORD_BITS-1:0];
    data_q[0] <= vdin;
    for (int k = 1; k < PIPE_DEPTH; k++) begin
      row_q[k]  <= row_q[k-1];
      word_q[k] <= word_q[k-1];
      data_q[k] <= data_q[k-1];
    end
  end

  assign rs_vld  = (op_q[SRAM_DELAY-1] == OP_READ);
  assign rs_word = word_q[SRAM_DELAY-1];
  assign cm_op   = op_q[PIPE_DEPTH-1];
  assign cm_row  = row_q[PIPE_DEPTH-1];
  assign cm_word = word_q[PIPE_DEPTH-1];
  assign cm_data = data_q[PIPE_DEPTH-1];

  assert property (@(posedge clk) disable iff (rst) !(vread && vwrite));
  assert property (@(posedge clk) disable iff (rst)
    (ready && vwrite) |-> ##PIPE_DEPTH (cm_op == OP_WRITE));

endmodule

//--- verilog/xmem_bank.sv
`timescale 1ns/1ps

module xmem_bank #(
  parameter int NUM_ROWS   = xmem_cfg_pkg::NUM_ROWS,
  parameter int ROW_BITS   = xmem_cfg_pkg::ROW_BITS,
  parameter int NUM_WORDS  = xmem_cfg_pkg::NUM_WORDS,
  parameter int WORD_WIDTH = xmem_cfg_pkg::WORD_WIDTH,
  parameter int SRAM_DELAY = xmem_cfg_pkg::SRAM_DELAY
) (
  input  logic                                 clk,
  input  logic                                 we,
  input  logic [ROW_BITS-1:0]                  wrow,
  input  logic [NUM_WORDS-1:0][WORD_WIDTH-1:0] din,
  input  logic                                 re,
  input  logic [ROW_BITS-1:0]                  rrow,
  output logic [NUM_WORDS-1:0][WORD_WIDTH-1:0] dout
);

  logic [NUM_WORDS-1:0][WORD_WIDTH-1:0] mem  [NUM_ROWS];
  logic [NUM_WORDS-1:0][WORD_WIDTH-1:0] rd_q [SRAM_DELAY];

  always_ff @(posedge clk) begin
    if (we)
      mem[wrow] <= din;
  end

  // same-row write in the read cycle returns the old row
  always_ff @(posedge clk) begin
    if (re)
      rd_q[0] <= mem[rrow];
    for (int k = 1; k < SRAM_DELAY; k++)
      rd_q[k] <= rd_q[k-1];
  end

  assign dout = rd_q[SRAM_DELAY-1];

endmodule

//--- verilog/xmem_fwd_pipe.sv
`timescale 1ns/1ps

module xmem_fwd_pipe #(
  parameter int ROW_BITS   = xmem_cfg_pkg::ROW_BITS,
  parameter int NUM_WORDS  = xmem_cfg_pkg::NUM_WORDS,
  parameter int WORD_WIDTH = xmem_cfg_pkg::WORD_WIDTH,
  parameter int SRAM_DELAY = xmem_cfg_pkg::SRAM_DELAY,
  parameter int PIPE_DEPTH = xmem_cfg_pkg::PIPE_DEPTH
) (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 iss_rd,
  input  logic [ROW_BITS-1:0]                  iss_row,
  input  logic                                 bk_we,
  input  logic [ROW_BITS-1:0]                  bk_row,
  input  logic [NUM_WORDS-1:0][WORD_WIDTH-1:0] bk_din,
  input  logic [NUM_WORDS-1:0][WORD_WIDTH-1:0] bk_dout,
  output logic [NUM_WORDS-1:0][WORD_WIDTH-1:0] rs_row,
  output logic [NUM_WORDS-1:0][WORD_WIDTH-1:0] cm_row_data,
  output logic                                 rs_fwd
);

  logic                                 req_q   [PIPE_DEPTH];
  logic [ROW_BITS-1:0]                  row_q   [PIPE_DEPTH];
  logic                                 vld_q   [PIPE_DEPTH];
  logic [NUM_WORDS-1:0][WORD_WIDTH-1:0] dat_q   [PIPE_DEPTH];
  // what each stage loads from, slot 0 is the issue cycle
  logic                                 src_req [PIPE_DEPTH];
  logic [ROW_BITS-1:0]                  src_row [PIPE_DEPTH];
  logic                                 src_vld [PIPE_DEPTH];
  logic [NUM_WORDS-1:0][WORD_WIDTH-1:0] src_dat [PIPE_DEPTH];
  logic [PIPE_DEPTH-1:0]                hit;

  assign src_req[0] = iss_rd;
  assign src_row[0] = iss_row;
  assign src_vld[0] = 1'b0;
  assign src_dat[0] = '0;

  for (genvar k = 1; k < PIPE_DEPTH; k++) begin : g_src
    assign src_req[k] = req_q[k-1];
    assign src_row[k] = row_q[k-1];
    assign src_vld[k] = vld_q[k-1];
    assign src_dat[k] = dat_q[k-1];
  end

  for (genvar k = 0; k < PIPE_DEPTH; k++) begin : g_hit
    assign hit[k] = bk_we && src_req[k] && (bk_row == src_row[k]);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int k = 0; k < PIPE_DEPTH; k++) begin
        req_q[k] <= 1'b0;
        vld_q[k] <= 1'b0;
      end
    end else begin
      for (int k = 0; k < PIPE_DEPTH; k++) begin
        req_q[k] <= src_req[k];
        vld_q[k] <= hit[k] || src_vld[k] || (k == SRAM_DELAY);
      end
    end
  end

  // newest bank write first, bank output only if nothing was caught
  always_ff @(posedge clk) begin
    for (int k = 0; k < PIPE_DEPTH; k++) begin
      row_q[k] <= src_row[k];
      if (hit[k])
        dat_q[k] <= bk_din;
      else if ((k == SRAM_DELAY) && !src_vld[k])
        dat_q[k] <= bk_dout;
      else
        dat_q[k] <= src_dat[k];
    end
  end

  assign rs_fwd      = vld_q[SRAM_DELAY-1];
  assign rs_row      = rs_fwd ? dat_q[SRAM_DELAY-1] : bk_dout;
  assign cm_row_data = vld_q[PIPE_DEPTH-1] ? dat_q[PIPE_DEPTH-1] : bk_dout;

endmodule

//--- verilog/xmem_read_merge.sv
`timescale 1ns/1ps

module xmem_read_merge #(
  parameter int NUM_PORTS  = xmem_cfg_pkg::NUM_PORTS,
  parameter int NUM_WORDS  = xmem_cfg_pkg::NUM_WORDS,
  parameter int WORD_WIDTH = xmem_cfg_pkg::WORD_WIDTH,
  parameter int WORD_BITS  = xmem_cfg_pkg::WORD_BITS
) (
  input  logic                                 rs_vld,
  input  logic [WORD_BITS-1:0]                 rs_word,
  input  logic [NUM_WORDS-1:0][WORD_WIDTH-1:0] col_rows [NUM_PORTS],
  output logic                                 rd_vld,
  output logic [WORD_WIDTH-1:0]                rd_data
);

  logic [NUM_WORDS-1:0][WORD_WIDTH-1:0] merged;

  // logical row is the xor down the column
  always_comb begin
    merged = '0;
    for (int r = 0; r < NUM_PORTS; r++)
      merged = merged ^ col_rows[r];
  end

  assign rd_vld  = rs_vld;
  assign rd_data = merged[rs_word];

endmodule

//--- verilog/xmem_write_encode.sv
`timescale 1ns/1ps

module xmem_write_encode #(
  parameter int NUM_PORTS  = xmem_cfg_pkg::NUM_PORTS,
  parameter int PORT_IDX   = 0,
  parameter int ROW_BITS   = xmem_cfg_pkg::ROW_BITS,
  parameter int WORD_BITS  = xmem_cfg_pkg::WORD_BITS,
  parameter int NUM_WORDS  = xmem_cfg_pkg::NUM_WORDS,
  parameter int WORD_WIDTH = xmem_cfg_pkg::WORD_WIDTH
) (
  input  logic                                 init_we,
  input  logic [ROW_BITS-1:0]                  init_row,
  input  xmem_op_pkg::xmem_op_e                cm_op,
  input  logic [ROW_BITS-1:0]                  cm_row,
  input  logic [WORD_BITS-1:0]                 cm_word,
  input  logic [WORD_WIDTH-1:0]                cm_data,
  input  xmem_op_pkg::xmem_op_e                oth_op   [NUM_PORTS],
  input  logic [ROW_BITS-1:0]                  oth_row  [NUM_PORTS],
  input  logic [WORD_BITS-1:0]                 oth_word [NUM_PORTS],
  input  logic [NUM_WORDS-1:0][WORD_WIDTH-1:0] col_rows [NUM_PORTS],
  output logic                                 bk_we,
  output logic [ROW_BITS-1:0]                  bk_row,
  output logic [NUM_WORDS-1:0][WORD_WIDTH-1:0] bk_din
);
  import xmem_op_pkg::*;

  logic                                 win;
  logic [WORD_WIDTH-1:0]                new_word;
  logic [NUM_WORDS-1:0][WORD_WIDTH-1:0] enc_row;

  // higher port index owns a same-word collision
  always_comb begin
    win = (cm_op == OP_WRITE);
    for (int q = PORT_IDX + 1; q < NUM_PORTS; q++) begin
      if ((oth_op[q] == OP_WRITE) && (oth_row[q] == cm_row) && (oth_word[q] == cm_word))
        win = 1'b0;
    end
  end

  // cancel the other grid rows so the column xor gives cm_data
  always_comb begin
    new_word = cm_data;
    for (int r = 0; r < NUM_PORTS; r++) begin
      if (r != PORT_IDX)
        new_word = new_word ^ col_rows[r][cm_word];
    end
    enc_row          = col_rows[PORT_IDX];
    enc_row[cm_word] = new_word;
  end

  always_comb begin
    if (init_we) begin
      bk_we  = 1'b1;
      bk_row = init_row;
      bk_din = '0;
    end else begin
      bk_we  = win;
      bk_row = cm_row;
      bk_din = enc_row;
    end
  end

  // requests are held off until ready, so no commit overlaps the sweep
  always_comb begin
    assert final (!(init_we && (cm_op == OP_WRITE)))
      else $error("write commit during reset sweep on port %0d", PORT_IDX);
  end

endmodule

//--- verilog/xmem_core.sv
`timescale 1ns/1ps

module xmem_core #(
  parameter int  NUM_PORTS  = xmem_cfg_pkg::NUM_PORTS,
  parameter int  WORD_WIDTH = xmem_cfg_pkg::WORD_WIDTH,
  parameter int  NUM_ROWS   = xmem_cfg_pkg::NUM_ROWS,
  parameter int  NUM_WORDS  = xmem_cfg_pkg::NUM_WORDS,
  parameter int  SRAM_DELAY = xmem_cfg_pkg::SRAM_DELAY,
  parameter int  UPD_DELAY  = xmem_cfg_pkg::UPD_DELAY,
  localparam int ROW_BITS   = $clog2(NUM_ROWS),
  localparam int WORD_BITS  = $clog2(NUM_WORDS),
  localparam int ADDR_BITS  = ROW_BITS + WORD_BITS,
  localparam int PIPE_DEPTH = SRAM_DELAY + UPD_DELAY
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [NUM_PORTS-1:0]  vread,
  input  logic [NUM_PORTS-1:0]  vwrite,
  input  logic [ADDR_BITS-1:0]  vaddr   [NUM_PORTS],
  input  logic [WORD_WIDTH-1:0] vdin    [NUM_PORTS],
  output logic [NUM_PORTS-1:0]  rd_vld,
  output logic [WORD_WIDTH-1:0] rd_data [NUM_PORTS],
  output logic                  ready
);
  import xmem_op_pkg::*;

  logic                                 init_we;
  logic [ROW_BITS-1:0]                  init_row;
  logic [NUM_PORTS-1:0]                 iss_rd;
  logic [ROW_BITS-1:0]                  iss_row [NUM_PORTS];
  logic [NUM_PORTS-1:0]                 rs_vld;
  logic [WORD_BITS-1:0]                 rs_word [NUM_PORTS];
  xmem_op_e                             cm_op   [NUM_PORTS];
  logic [ROW_BITS-1:0]                  cm_row  [NUM_PORTS];
  logic [WORD_BITS-1:0]                 cm_word [NUM_PORTS];
  logic [WORD_WIDTH-1:0]                cm_data [NUM_PORTS];
  logic [NUM_PORTS-1:0]                 bk_we;
  logic [ROW_BITS-1:0]                  bk_row  [NUM_PORTS];
  logic [NUM_WORDS-1:0][WORD_WIDTH-1:0] bk_din  [NUM_PORTS];
  // [grid row][grid col]
  logic [NUM_WORDS-1:0][WORD_WIDTH-1:0] bk_dout [NUM_PORTS][NUM_PORTS];
  // [reading port][grid row]
  logic [NUM_WORDS-1:0][WORD_WIDTH-1:0] rs_rows [NUM_PORTS][NUM_PORTS];
  logic [NUM_WORDS-1:0][WORD_WIDTH-1:0] cm_rows [NUM_PORTS][NUM_PORTS];

  xmem_init_ctrl #(.NUM_ROWS(NUM_ROWS), .ROW_BITS(ROW_BITS), .PIPE_DEPTH(PIPE_DEPTH)) u_init (
    .clk(clk), .rst(rst), .ready(ready), .init_we(init_we), .init_row(init_row)
  );

  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
    xmem_port_pipe #(
      .ADDR_BITS(ADDR_BITS), .ROW_BITS(ROW_BITS), .WORD_BITS(WORD_BITS),
      .WORD_WIDTH(WORD_WIDTH), .SRAM_DELAY(SRAM_DELAY), .PIPE_DEPTH(PIPE_DEPTH)
    ) u_pipe (
      .clk(clk), .rst(rst), .ready(ready), .vread(vread[p]), .vwrite(vwrite[p]),
      .vaddr(vaddr[p]), .vdin(vdin[p]), .iss_rd(iss_rd[p]), .iss_row(iss_row[p]),
      .rs_vld(rs_vld[p]), .rs_word(rs_word[p]), .cm_op(cm_op[p]), .cm_row(cm_row[p]),
      .cm_word(cm_word[p]), .cm_data(cm_data[p])
    );

    xmem_read_merge #(
      .NUM_PORTS(NUM_PORTS), .NUM_WORDS(NUM_WORDS), .WORD_WIDTH(WORD_WIDTH),
      .WORD_BITS(WORD_BITS)
    ) u_merge (
      .rs_vld(rs_vld[p]), .rs_word(rs_word[p]), .col_rows(rs_rows[p]),
      .rd_vld(rd_vld[p]), .rd_data(rd_data[p])
    );

    xmem_write_encode #(
      .NUM_PORTS(NUM_PORTS), .PORT_IDX(p), .ROW_BITS(ROW_BITS), .WORD_BITS(WORD_BITS),
      .NUM_WORDS(NUM_WORDS), .WORD_WIDTH(WORD_WIDTH)
    ) u_enc (
      .init_we(init_we), .init_row(init_row), .cm_op(cm_op[p]), .cm_row(cm_row[p]),
      .cm_word(cm_word[p]), .cm_data(cm_data[p]), .oth_op(cm_op), .oth_row(cm_row),
      .oth_word(cm_word), .col_rows(cm_rows[p]), .bk_we(bk_we[p]), .bk_row(bk_row[p]),
      .bk_din(bk_din[p])
    );
  end

  // grid row r is written by port r, grid col c is read by port c
  for (genvar r = 0; r < NUM_PORTS; r++) begin : g_row
    for (genvar c = 0; c < NUM_PORTS; c++) begin : g_col
      xmem_bank #(
        .NUM_ROWS(NUM_ROWS), .ROW_BITS(ROW_BITS), .NUM_WORDS(NUM_WORDS),
        .WORD_WIDTH(WORD_WIDTH), .SRAM_DELAY(SRAM_DELAY)
      ) u_bank (
        .clk(clk), .we(bk_we[r]), .wrow(bk_row[r]), .din(bk_din[r]),
        .re(iss_rd[c]), .rrow(iss_row[c]), .dout(bk_dout[r][c])
      );

      xmem_fwd_pipe #(
        .ROW_BITS(ROW_BITS), .NUM_WORDS(NUM_WORDS), .WORD_WIDTH(WORD_WIDTH),
        .SRAM_DELAY(SRAM_DELAY), .PIPE_DEPTH(PIPE_DEPTH)
      ) u_fwd (
        .clk(clk), .rst(rst), .iss_rd(iss_rd[c]), .iss_row(iss_row[c]),
        .bk_we(bk_we[r]), .bk_row(bk_row[r]), .bk_din(bk_din[r]), .bk_dout(bk_dout[r][c]),
        .rs_row(rs_rows[c][r]), .cm_row_data(cm_rows[c][r]), .rs_fwd()
      );
    end
  end

endmodule

//--- verif/xmem_ref_model.sv
`timescale 1ns/1ps

module xmem_ref_model #(
  parameter int NUM_PORTS  = xmem_cfg_pkg::NUM_PORTS,
  parameter int WORD_WIDTH = xmem_cfg_pkg::WORD_WIDTH,
  parameter int ADDR_BITS  = xmem_cfg_pkg::ADDR_BITS,
  parameter int SRAM_DELAY = xmem_cfg_pkg::SRAM_DELAY,
  parameter int PIPE_DEPTH = xmem_cfg_pkg::PIPE_DEPTH,
  parameter int READY_CYC  = xmem_cfg_pkg::NUM_ROWS + xmem_cfg_pkg::PIPE_DEPTH + 1
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [NUM_PORTS-1:0]  vread,
  input  logic [NUM_PORTS-1:0]  vwrite,
  input  logic [ADDR_BITS-1:0]  vaddr    [NUM_PORTS],
  input  logic [WORD_WIDTH-1:0] vdin     [NUM_PORTS],
  output logic [NUM_PORTS-1:0]  exp_vld,
  output logic [NUM_PORTS-1:0]  exp_skip,
  output logic [WORD_WIDTH-1:0] exp_data [NUM_PORTS]
);

  localparam int UPD_DELAY = PIPE_DEPTH - SRAM_DELAY;

  logic [WORD_WIDTH-1:0] mem     [2**ADDR_BITS];
  // stage j holds writes taken j+1 cycles ago
  logic                  wr_vld  [PIPE_DEPTH][NUM_PORTS];
  logic [ADDR_BITS-1:0]  wr_addr [PIPE_DEPTH][NUM_PORTS];
  logic [WORD_WIDTH-1:0] wr_data [PIPE_DEPTH][NUM_PORTS];
  logic                  rd_vld  [SRAM_DELAY][NUM_PORTS];
  logic                  rd_skip [SRAM_DELAY][NUM_PORTS];
  logic [WORD_WIDTH-1:0] rd_data [SRAM_DELAY][NUM_PORTS];
  int                    live_cnt;

  always @(posedge clk) begin
    if (rst) begin
      live_cnt = 0;
      for (int a = 0; a < 2**ADDR_BITS; a++)
        mem[a] = '0;
      for (int p = 0; p < NUM_PORTS; p++) begin
        for (int j = 0; j < PIPE_DEPTH; j++)
          wr_vld[j][p] = 1'b0;
        for (int k = 0; k < SRAM_DELAY; k++)
          rd_vld[k][p] = 1'b0;
      end
    end else begin
      if (live_cnt < READY_CYC)
        live_cnt++;
      for (int p = 0; p < NUM_PORTS; p++) begin
        for (int k = SRAM_DELAY - 1; k > 0; k--) begin
          rd_vld[k][p]  = rd_vld[k-1][p];
          rd_skip[k][p] = rd_skip[k-1][p];
          rd_data[k][p] = rd_data[k-1][p];
        end
        // read sees the word before this cycle's commits
        rd_vld[0][p]  = (live_cnt == READY_CYC) && vread[p] && !vwrite[p];
        rd_data[0][p] = mem[vaddr[p]];
        rd_skip[0][p] = 1'b0;
        // commits landing while the read is in flight
        for (int j = UPD_DELAY; j < PIPE_DEPTH; j++)
          for (int q = 0; q < NUM_PORTS; q++)
            if (wr_vld[j][q] && (wr_addr[j][q] == vaddr[p]))
              rd_skip[0][p] = 1'b1;
      end
      // ascending order, so the higher port wins a tie
      for (int p = 0; p < NUM_PORTS; p++)
        if (wr_vld[PIPE_DEPTH-1][p])
          mem[wr_addr[PIPE_DEPTH-1][p]] = wr_data[PIPE_DEPTH-1][p];
      for (int p = 0; p < NUM_PORTS; p++) begin
        for (int j = PIPE_DEPTH - 1; j > 0; j--) begin
          wr_vld[j][p]  = wr_vld[j-1][p];
          wr_addr[j][p] = wr_addr[j-1][p];
          wr_data[j][p] = wr_data[j-1][p];
        end
        wr_vld[0][p]  = (live_cnt == READY_CYC) && vwrite[p];
        wr_addr[0][p] = vaddr[p];
        wr_data[0][p] = vdin[p];
      end
    end
  end

  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_out
    assign exp_vld[p]  = rd_vld[SRAM_DELAY-1][p];
    assign exp_skip[p] = rd_skip[SRAM_DELAY-1][p];
    assign exp_data[p] = rd_data[SRAM_DELAY-1][p];
  end

endmodule

//--- verif/xmem_tb.sv
`timescale 1ns/1ps

module xmem_tb;
  import xmem_cfg_pkg::*;

  localparam int          TIMEOUT   = 200;
  localparam int          READY_CYC = NUM_ROWS + PIPE_DEPTH + 1;
  localparam logic [31:0] SEED      = 32'hb536_49eb;

  logic                  clk;
  logic                  rst;
  logic [NUM_PORTS-1:0]  vread;
  logic [NUM_PORTS-1:0]  vwrite;
  logic [ADDR_BITS-1:0]  vaddr    [NUM_PORTS];
  logic [WORD_WIDTH-1:0] vdin     [NUM_PORTS];
  logic [NUM_PORTS-1:0]  rd_vld;
  logic [WORD_WIDTH-1:0] rd_data  [NUM_PORTS];
  logic                  ready;
  logic [NUM_PORTS-1:0]  exp_vld;
  logic [NUM_PORTS-1:0]  exp_skip;
  logic [WORD_WIDTH-1:0] exp_data [NUM_PORTS];

  string cur_test;
  int    test_start;
  int    n_errors;
  int    n_checks;
  int    n_skipped;
  int    n_tests;
  int    n_failed;

  xmem_core #(
    .NUM_PORTS(NUM_PORTS), .WORD_WIDTH(WORD_WIDTH), .NUM_ROWS(NUM_ROWS),
    .NUM_WORDS(NUM_WORDS), .SRAM_DELAY(SRAM_DELAY), .UPD_DELAY(UPD_DELAY)
  ) u_dut (
    .clk(clk), .rst(rst), .vread(vread), .vwrite(vwrite), .vaddr(vaddr), .vdin(vdin),
    .rd_vld(rd_vld), .rd_data(rd_data), .ready(ready)
  );

  xmem_ref_model #(
    .NUM_PORTS(NUM_PORTS), .WORD_WIDTH(WORD_WIDTH), .ADDR_BITS(ADDR_BITS),
    .SRAM_DELAY(SRAM_DELAY), .PIPE_DEPTH(PIPE_DEPTH), .READY_CYC(READY_CYC)
  ) u_model (
    .clk(clk), .rst(rst), .vread(vread), .vwrite(vwrite), .vaddr(vaddr), .vdin(vdin),
    .exp_vld(exp_vld), .exp_skip(exp_skip), .exp_data(exp_data)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  task automatic report_mismatch(input string what, input logic [WORD_WIDTH-1:0] exp,
                                 input logic [WORD_WIDTH-1:0] act);
    $display("error %s: %s expected %h actual %h", cur_test, what, exp, act);
    n_errors++;
  endtask

  task automatic report_failure(input string msg);
    $display("%s: %s", cur_test, msg);
    n_errors++;
  endtask

  // every read return is compared mid-cycle
  always @(negedge clk) begin
    if (!rst) begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        assert (rd_vld[p] == exp_vld[p])
          else report_mismatch($sformatf("port %0d rd_vld", p), exp_vld[p], rd_vld[p]);
        if (exp_vld[p] && exp_skip[p]) begin
          n_skipped++;
        end else if (exp_vld[p]) begin
          n_checks++;
          assert (rd_data[p] == exp_data[p])
            else report_mismatch($sformatf("port %0d rd_data", p), exp_data[p], rd_data[p]);
        end
      end
    end
  end

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic drive_idle();
    vread  = '0;
    vwrite = '0;
  endtask

  task automatic drive_req(input int p, input bit wr, input logic [ADDR_BITS-1:0] addr,
                           input logic [WORD_WIDTH-1:0] data);
    vread[p]  = !wr;
    vwrite[p] = wr;
    vaddr[p]  = addr;
    vdin[p]   = data;
  endtask

  task automatic drain();
    repeat (PIPE_DEPTH + 2) begin
      next_cycle();
      drive_idle();
    end
  endtask

  task automatic apply_reset();
    drive_idle();
    rst = 1'b1;
    repeat (10) @(posedge clk);
    #1;
    assert (ready == 1'b0) else report_mismatch("ready in reset", '0, ready);
    assert (rd_vld == '0) else report_mismatch("rd_vld in reset", '0, rd_vld);
    rst = 1'b0;
  endtask

  task automatic wait_ready(output int cycles);
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!ready && cycles < TIMEOUT);
    assert (ready) else report_failure("ready never rose");
  endtask

  // one read, then wait for its return
  task automatic issue_read(input int p, input logic [ADDR_BITS-1:0] addr,
                            output logic [WORD_WIDTH-1:0] data);
    int lat;
    next_cycle();
    drive_idle();
    drive_req(p, 1'b0, addr, '0);
    next_cycle();
    drive_idle();
    lat = 1;
    @(negedge clk);
    while (!rd_vld[p] && lat < TIMEOUT) begin
      lat++;
      @(negedge clk);
    end
    assert (rd_vld[p]) else report_failure($sformatf("no read return on port %0d", p));
    assert (lat == SRAM_DELAY) else report_mismatch("read latency", SRAM_DELAY, lat);
    data = rd_data[p];
  endtask

  task automatic start_test(input string name);
    cur_test   = name;
    test_start = n_errors;
  endtask

  task automatic end_test();
    n_tests++;
    if (n_errors == test_start) begin
      $display("test %s: pass", cur_test);
    end else begin
      n_failed++;
      $display("test %s: fail with %0d errors", cur_test, n_errors - test_start);
    end
  endtask

  initial begin
    int                    cycles;
    int                    op;
    logic [WORD_WIDTH-1:0] got;
    logic [WORD_WIDTH-1:0] d0;
    logic [ADDR_BITS-1:0]  addr;
    void'($urandom(SEED));
    rst = 1'b1;
    drive_idle();
    for (int p = 0; p < NUM_PORTS; p++) begin
      vaddr[p] = '0;
      vdin[p]  = '0;
    end
    n_errors = 0;
    n_checks = 0;
    n_skipped = 0;
    n_tests = 0;
    n_failed = 0;

    start_test("reset_ready");
    apply_reset();
    wait_ready(cycles);
    assert (cycles == READY_CYC) else report_mismatch("cycles to ready", READY_CYC, cycles);
    end_test();

    start_test("read_zero");
    for (int i = 0; i < 8; i++) begin
      issue_read(i % NUM_PORTS, ADDR_BITS'($urandom), got);
      assert (got == '0) else report_mismatch("read data", '0, got);
    end
    end_test();

    // small range, so rows are shared
    start_test("single_port_rw");
    for (int i = 0; i < 24; i++) begin
      next_cycle();
      drive_idle();
      drive_req(0, 1'b1, ADDR_BITS'($urandom % 8), $urandom);
    end
    drain();
    for (int a = 0; a < 8; a++)
      issue_read(0, ADDR_BITS'(a), got);
    end_test();

    start_test("dual_port_random");
    for (int i = 0; i < 400; i++) begin
      next_cycle();
      drive_idle();
      for (int p = 0; p < NUM_PORTS; p++) begin
        op = $urandom % 3;
        if (op != 0)
          drive_req(p, op == 2, ADDR_BITS'($urandom % 16), $urandom);
      end
    end
    drain();
    end_test();

    start_test("write_conflict");
    addr = ADDR_BITS'($urandom % 16);
    d0   = $urandom;
    next_cycle();
    drive_idle();
    drive_req(0, 1'b1, addr, d0);
    drive_req(NUM_PORTS - 1, 1'b1, addr, ~d0);
    drain();
    for (int p = 0; p < NUM_PORTS; p++) begin
      issue_read(p, addr, got);
      assert (got == ~d0) else report_mismatch("conflict winner", ~d0, got);
    end
    end_test();

    // sweep clears everything, requests meanwhile are dropped
    start_test("ignore_before_ready");
    next_cycle();
    apply_reset();
    cycles = 0;
    do begin
      drive_idle();
      for (int p = 0; p < NUM_PORTS; p++)
        drive_req(p, ((cycles + p) % 2) == 0, ADDR_BITS'($urandom % 16), $urandom);
      next_cycle();
      cycles++;
    end while (!ready && cycles < TIMEOUT);
    drive_idle();
    assert (ready) else report_failure("ready never rose after the second reset");
    for (int a = 0; a < 16; a++) begin
      issue_read(a % NUM_PORTS, ADDR_BITS'(a), got);
      assert (got == '0) else report_mismatch("read after sweep", '0, got);
    end
    end_test();

    $display("%0d tests, %0d failed, %0d reads checked, %0d skipped, %0d errors",
             n_tests, n_failed, n_checks, n_skipped, n_errors);
    if (n_errors == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

//--- verilog.f
verilog/xmem_cfg_pkg.sv
verilog/xmem_op_pkg.sv
verilog/xmem_init_ctrl.sv
verilog/xmem_port_pipe.sv
verilog/xmem_bank.sv
verilog/xmem_fwd_pipe.sv
verilog/xmem_read_merge.sv
verilog/xmem_write_encode.sv
verilog/xmem_core.sv
verif/xmem_ref_model.sv
verif/xmem_tb.sv

//--- Bender.yml
package:
  name: xmem

sources:
  - files:
      - verilog/xmem_cfg_pkg.sv
      - verilog/xmem_op_pkg.sv
      - verilog/xmem_init_ctrl.sv
      - verilog/xmem_port_pipe.sv
      - verilog/xmem_bank.sv
      - verilog/xmem_fwd_pipe.sv
      - verilog/xmem_read_merge.sv
      - verilog/xmem_write_encode.sv
      - verilog/xmem_core.sv
  - target: test
    files:
      - verif/xmem_ref_model.sv
      - verif/xmem_tb.sv
